/* list.f */
+incdir+source
source/cpu_pkg.sv
source/instr_memory.sv
source/fetch_stage.sv
source/decode_stage.sv
source/hazard_unit.sv
source/execute_stage.sv
source/data_memory.sv
source/cpu.sv
tb/cpu_assertions.sv
tb/cpu_tb.sv

/* run.sh */
#!/bin/sh
# Build the cpu testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu_tb \
	-f list.f -Mdir obj_dir -o cpu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/cpu_sim)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation returned status $sim_status"
	exit 1
fi

# Pass only when the testbench printed its pass line
if printf '%s\n' "$sim_output" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1

/* source/cpu.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module cpu (
	input  logic                  clk,
	input  logic                  reset,
	input  cpu_pkg::imem_load_t   imem_load,
	output logic                  hlt,
	output logic [`CPU_WIDTH-1:0] halt_pc,
	output cpu_pkg::retire_t      retire
);

	// Stage-to-stage registers
	cpu_pkg::fetch_out_t  fetch_out;
	cpu_pkg::decode_out_t decode_out;
	cpu_pkg::exec_out_t   exec_out;
	cpu_pkg::wb_out_t     wb_out;

	cpu_pkg::instr_t       instr;
	logic [`CPU_WIDTH-1:0] iaddr, branch_target;
	logic                  stall, flush, halt_seen, branch_taken;
	cpu_pkg::reg_addr_t    src0_addr, src1_addr;
	cpu_pkg::fwd_sel_t     fwd_a, fwd_b;

	//////////////////////////////////////////////////////////////////////
	// Front end
	//////////////////////////////////////////////////////////////////////

	instr_memory imem (
		.clk(clk),
		.imem_load(imem_load),
		.addr(iaddr),
		.instr(instr)
	);

	fetch_stage instruction_fetch (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.flush(flush),
		.halt_seen(halt_seen),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.instr(instr),
		.iaddr(iaddr),
		.fetch_out(fetch_out)
	);

	// Register writes come back from write-back
	decode_stage instruction_decode (
		.clk(clk),
		.reset(reset),
		.fetch_in(fetch_out),
		.wb_in(wb_out),
		.stall(stall),
		.flush(flush),
		.decode_out(decode_out),
		.halt_seen(halt_seen),
		.src0_addr(src0_addr),
		.src1_addr(src1_addr)
	);

	hazard_unit hazard_detection (
		.src0_addr(src0_addr),
		.src1_addr(src1_addr),
		.decode_in(decode_out),
		.exec_in(exec_out),
		.wb_in(wb_out),
		.branch_taken(branch_taken),
		.stall(stall),
		.flush(flush),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b)
	);

	//////////////////////////////////////////////////////////////////////
	// Back end
	//////////////////////////////////////////////////////////////////////

	execute_stage execution (
		.clk(clk),
		.reset(reset),
		.decode_in(decode_out),
		.exec_mem(exec_out),
		.wb_in(wb_out),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.exec_out(exec_out)
	);

	data_memory memory (
		.clk(clk),
		.reset(reset),
		.exec_in(exec_out),
		.mem_out(wb_out)
	);

	// Sticky halt flag set by the HLT in write-back
	always_ff @(posedge clk) begin
		if (reset)
			hlt <= 1'b0;
		else if (wb_out.valid && wb_out.halt)
			hlt <= 1'b1;
	end

	// Address of the HLT that ended the program
	always_ff @(posedge clk) begin
		if (wb_out.valid && wb_out.halt && !hlt)
			halt_pc <= wb_out.pc;
	end

	// One pulse per register write in program order
	always_comb begin
		retire.valid = wb_out.valid && wb_out.reg_write;
		retire.pc    = wb_out.pc;
		retire.dst   = wb_out.dst;
		retire.data  = wb_out.data;
	end

endmodule

`default_nettype wire

/* source/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath and instruction word width
`define CPU_WIDTH      16
// Register file size, r0 reads as zero
`define CPU_REGS       16
// Memory depths in words
`define CPU_IMEM_DEPTH 256
`define CPU_DMEM_DEPTH 256

// Opcodes, top nibble of the instruction
`define CPU_OP_ADD     4'd0
`define CPU_OP_SUB     4'd2
`define CPU_OP_AND     4'd3
`define CPU_OP_NOR     4'd4
`define CPU_OP_LW      4'd8
`define CPU_OP_SW      4'd9
`define CPU_OP_LLB     4'd10
`define CPU_OP_LHB     4'd11
`define CPU_OP_BZ      4'd12
`define CPU_OP_HLT     4'd15

`endif

/* source/cpu_pkg.sv */
`default_nettype none
`include "cpu_defs.svh"

package cpu_pkg;

	typedef logic [`CPU_WIDTH-1:0] word_t;
	typedef logic [$clog2(`CPU_REGS)-1:0] reg_addr_t;

	// Register form, also used by LW and SW
	typedef struct packed {
		logic [3:0] opcode;
		reg_addr_t  dst;
		reg_addr_t  src0;
		reg_addr_t  src1;
	} r_form_t;

	// Immediate form for LLB, LHB and BZ
	typedef struct packed {
		logic [3:0] opcode;
		reg_addr_t  dst;
		logic [7:0] imm;
	} i_form_t;

	// Same word, two views
	typedef union packed {
		r_form_t r_form;
		i_form_t i_form;
	} instr_t;

	typedef struct packed {
		logic   valid;
		word_t  pc;
		instr_t instr;
	} fetch_out_t;

	typedef struct packed {
		logic       valid;
		word_t      pc;
		logic [3:0] op;
		word_t      a;
		word_t      b;
		reg_addr_t  src_a;
		reg_addr_t  src_b;
		reg_addr_t  dst;
		word_t      imm;
		logic       reg_write;
		logic       load;
		logic       store;
		logic       branch;
		logic       halt;
	} decode_out_t;

	typedef struct packed {
		logic      valid;
		word_t     pc;
		word_t     result;
		word_t     store_data;
		reg_addr_t dst;
		logic      reg_write;
		logic      load;
		logic      store;
		logic      halt;
	} exec_out_t;

	typedef struct packed {
		logic      valid;
		word_t     pc;
		reg_addr_t dst;
		word_t     data;
		logic      reg_write;
		logic      halt;
	} wb_out_t;

	typedef struct packed {
		logic      valid;
		word_t     pc;
		reg_addr_t dst;
		word_t     data;
	} retire_t;

	typedef struct packed {
		logic  we;
		word_t addr;
		word_t data;
	} imem_load_t;

	// Operand source for execute
	typedef enum logic [1:0] {
		FWD_RF  = 2'd0,
		FWD_MEM = 2'd1,
		FWD_WB  = 2'd2
	} fwd_sel_t;

endpackage

`default_nettype wire

/* source/data_memory.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module data_memory (
	input  logic               clk,
	input  logic               reset,
	input  cpu_pkg::exec_out_t exec_in,
	output cpu_pkg::wb_out_t   mem_out
);

	localparam int DADDR_BITS = $clog2(`CPU_DMEM_DEPTH);

	cpu_pkg::word_t        ram [`CPU_DMEM_DEPTH];
	logic [DADDR_BITS-1:0] addr;
	cpu_pkg::word_t        rdata;

	// Address truncated to the RAM depth
	assign addr  = exec_in.result[DADDR_BITS-1:0];
	assign rdata = ram[addr];

	// Store lands at the end of this cycle
	always_ff @(posedge clk) begin
		if (exec_in.valid && exec_in.store)
			ram[addr] <= exec_in.store_data;
	end

	//////////////////////////////////////////////////////////////////////
	// Memory-to-write-back register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset)
			mem_out.valid <= 1'b0;
		else
			mem_out.valid <= exec_in.valid;
	end

	// Load data or ALU result
	always_ff @(posedge clk) begin
		mem_out.pc        <= exec_in.pc;
		mem_out.dst       <= exec_in.dst;
		mem_out.data      <= exec_in.load ? rdata : exec_in.result;
		mem_out.reg_write <= exec_in.reg_write;
		mem_out.halt      <= exec_in.halt;
	end

endmodule

`default_nettype wire

/* source/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module decode_stage (
	input  logic                 clk,
	input  logic                 reset,
	input  cpu_pkg::fetch_out_t  fetch_in,
	input  cpu_pkg::wb_out_t     wb_in,
	input  logic                 stall,
	input  logic                 flush,
	output cpu_pkg::decode_out_t decode_out,
	output logic                 halt_seen,
	output cpu_pkg::reg_addr_t   src0_addr,
	output cpu_pkg::reg_addr_t   src1_addr
);

	cpu_pkg::word_t     regs [`CPU_REGS];
	cpu_pkg::instr_t    instr;
	logic [3:0]         opcode;
	cpu_pkg::reg_addr_t src_a, src_b;
	cpu_pkg::word_t     imm, operand_a, operand_b;
	logic               reg_write, load, store, branch, is_hlt;
	logic               halt_q, take;

	// Read with write-back bypass, r0 pinned to zero
	function automatic cpu_pkg::word_t read_reg(input cpu_pkg::reg_addr_t ra);
		if (ra == '0)
			return '0;
		if (wb_in.valid && wb_in.reg_write && wb_in.dst == ra)
			return wb_in.data;
		return regs[ra];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Register file
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wb_in.valid && wb_in.reg_write)
			regs[wb_in.dst] <= wb_in.data;
	end

	//////////////////////////////////////////////////////////////////////
	// Instruction decode
	//////////////////////////////////////////////////////////////////////

	assign instr  = fetch_in.instr;
	assign opcode = instr.r_form.opcode;
	assign is_hlt = (opcode == `CPU_OP_HLT);

	always_comb begin
		src_a     = '0;
		src_b     = '0;
		imm       = '0;
		reg_write = 1'b0;
		load      = 1'b0;
		store     = 1'b0;
		branch    = 1'b0;
		case (opcode)
			`CPU_OP_ADD, `CPU_OP_SUB, `CPU_OP_AND, `CPU_OP_NOR: begin
				src_a     = instr.r_form.src0;
				src_b     = instr.r_form.src1;
				reg_write = 1'b1;
			end
			// Base in src0, signed word offset in src1
			`CPU_OP_LW: begin
				src_a     = instr.r_form.src0;
				imm       = {{(`CPU_WIDTH-4){instr.r_form.src1[3]}}, instr.r_form.src1};
				reg_write = 1'b1;
				load      = 1'b1;
			end
			// Store data comes from the dst field
			`CPU_OP_SW: begin
				src_a = instr.r_form.src0;
				src_b = instr.r_form.dst;
				imm   = {{(`CPU_WIDTH-4){instr.r_form.src1[3]}}, instr.r_form.src1};
				store = 1'b1;
			end
			`CPU_OP_LLB: begin
				imm       = {{(`CPU_WIDTH-8){instr.i_form.imm[7]}}, instr.i_form.imm};
				reg_write = 1'b1;
			end
			// Old value needed for the kept low byte
			`CPU_OP_LHB: begin
				src_a     = instr.i_form.dst;
				imm       = {{(`CPU_WIDTH-8){instr.i_form.imm[7]}}, instr.i_form.imm};
				reg_write = 1'b1;
			end
			// Tested register lives in dst
			`CPU_OP_BZ: begin
				src_a  = instr.i_form.dst;
				imm    = {{(`CPU_WIDTH-8){instr.i_form.imm[7]}}, instr.i_form.imm};
				branch = 1'b1;
			end
			default: ;
		endcase
	end

	always_comb begin
		operand_a = read_reg(src_a);
		operand_b = read_reg(src_b);
	end

	// Hazard checks only see live sources
	assign src0_addr = fetch_in.valid ? src_a : '0;
	assign src1_addr = fetch_in.valid ? src_b : '0;

	// Older taken branch cancels a halt here
	assign take      = fetch_in.valid && !stall && !flush && !halt_q;
	assign halt_seen = halt_q || (fetch_in.valid && is_hlt && !flush);

	//////////////////////////////////////////////////////////////////////
	// Decode-to-execute register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			decode_out.valid <= 1'b0;
			halt_q           <= 1'b0;
		end else begin
			decode_out.valid <= take;
			if (take && is_hlt)
				halt_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		decode_out.pc        <= fetch_in.pc;
		decode_out.op        <= opcode;
		decode_out.a         <= operand_a;
		decode_out.b         <= operand_b;
		decode_out.src_a     <= src_a;
		decode_out.src_b     <= src_b;
		decode_out.dst       <= instr.r_form.dst;
		decode_out.imm       <= imm;
		decode_out.reg_write <= reg_write && (instr.r_form.dst != '0);
		decode_out.load      <= load;
		decode_out.store     <= store;
		decode_out.branch    <= branch;
		decode_out.halt      <= is_hlt;
	end

endmodule

`default_nettype wire

/* source/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module execute_stage (
	input  logic                  clk,
	input  logic                  reset,
	input  cpu_pkg::decode_out_t  decode_in,
	input  cpu_pkg::exec_out_t    exec_mem,
	input  cpu_pkg::wb_out_t      wb_in,
	input  cpu_pkg::fwd_sel_t     fwd_a,
	input  cpu_pkg::fwd_sel_t     fwd_b,
	output logic                  branch_taken,
	output logic [`CPU_WIDTH-1:0] branch_target,
	output cpu_pkg::exec_out_t    exec_out
);

	cpu_pkg::word_t op_a, op_b, alu;

	// One forwarding mux, used for both operands
	function automatic cpu_pkg::word_t forward_pick(
		input cpu_pkg::fwd_sel_t sel,
		input cpu_pkg::word_t    rf_val,
		input cpu_pkg::word_t    mem_val,
		input cpu_pkg::word_t    wb_val
	);
		case (sel)
			cpu_pkg::FWD_MEM: return mem_val;
			cpu_pkg::FWD_WB:  return wb_val;
			default:          return rf_val;
		endcase
	endfunction

	assign op_a = forward_pick(fwd_a, decode_in.a, exec_mem.result, wb_in.data);
	assign op_b = forward_pick(fwd_b, decode_in.b, exec_mem.result, wb_in.data);

	//////////////////////////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (decode_in.op)
			`CPU_OP_ADD: alu = op_a + op_b;
			`CPU_OP_SUB: alu = op_a - op_b;
			`CPU_OP_AND: alu = op_a & op_b;
			`CPU_OP_NOR: alu = ~(op_a | op_b);
			`CPU_OP_LLB: alu = decode_in.imm;
			// New upper byte over the old lower byte
			`CPU_OP_LHB: alu = {decode_in.imm[7:0], op_a[7:0]};
			// Effective address
			`CPU_OP_LW, `CPU_OP_SW: alu = op_a + decode_in.imm;
			default: alu = '0;
		endcase
	end

	// BZ on the forwarded dst register
	assign branch_taken  = decode_in.valid && decode_in.branch && (op_a == '0);
	assign branch_target = decode_in.pc + decode_in.imm + 1'b1;

	//////////////////////////////////////////////////////////////////////
	// Execute-to-memory register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset)
			exec_out.valid <= 1'b0;
		else
			exec_out.valid <= decode_in.valid;
	end

	always_ff @(posedge clk) begin
		exec_out.pc         <= decode_in.pc;
		exec_out.result     <= alu;
		exec_out.store_data <= op_b;
		exec_out.dst        <= decode_in.dst;
		exec_out.reg_write  <= decode_in.reg_write;
		exec_out.load       <= decode_in.load;
		exec_out.store      <= decode_in.store;
		exec_out.halt       <= decode_in.halt;
	end

endmodule

`default_nettype wire

/* source/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module fetch_stage (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  stall,
	input  logic                  flush,
	input  logic                  halt_seen,
	input  logic                  branch_taken,
	input  logic [`CPU_WIDTH-1:0] branch_target,
	input  cpu_pkg::instr_t       instr,
	output logic [`CPU_WIDTH-1:0] iaddr,
	output cpu_pkg::fetch_out_t   fetch_out
);

	logic [`CPU_WIDTH-1:0] pc;
	logic                  hold;

	// Frozen on load-use stall or once a halt sits in decode
	assign hold  = stall || halt_seen;
	assign iaddr = pc;

	// Program counter, branch wins over hold
	always_ff @(posedge clk) begin
		if (reset)
			pc <= '0;
		else if (branch_taken)
			pc <= branch_target;
		else if (!hold)
			pc <= pc + 1'b1;
	end

	// Fetch-to-decode valid
	always_ff @(posedge clk) begin
		if (reset || flush)
			fetch_out.valid <= 1'b0;
		else if (!hold)
			fetch_out.valid <= 1'b1;
	end

	// Payload, held together with valid
	always_ff @(posedge clk) begin
		if (!hold) begin
			fetch_out.pc    <= pc;
			fetch_out.instr <= instr;
		end
	end

endmodule

`default_nettype wire

/* source/hazard_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
	input  cpu_pkg::reg_addr_t   src0_addr,
	input  cpu_pkg::reg_addr_t   src1_addr,
	input  cpu_pkg::decode_out_t decode_in,
	input  cpu_pkg::exec_out_t   exec_in,
	input  cpu_pkg::wb_out_t     wb_in,
	input  logic                 branch_taken,
	output logic                 stall,
	output logic                 flush,
	output cpu_pkg::fwd_sel_t    fwd_a,
	output cpu_pkg::fwd_sel_t    fwd_b
);

	logic load_in_ex;

	// Youngest writer first, load data not ready in memory stage
	function automatic cpu_pkg::fwd_sel_t forward_from(input cpu_pkg::reg_addr_t src);
		if (src == '0)
			return cpu_pkg::FWD_RF;
		if (exec_in.valid && exec_in.reg_write && !exec_in.load && exec_in.dst == src)
			return cpu_pkg::FWD_MEM;
		if (wb_in.valid && wb_in.reg_write && wb_in.dst == src)
			return cpu_pkg::FWD_WB;
		return cpu_pkg::FWD_RF;
	endfunction

	// Operands of the instruction now in execute
	always_comb begin
		fwd_a = forward_from(decode_in.src_a);
		fwd_b = forward_from(decode_in.src_b);
	end

	// Load-use: one bubble, then the value comes from write-back
	assign load_in_ex = decode_in.valid && decode_in.load && (decode_in.dst != '0);
	assign stall      = load_in_ex &&
		((decode_in.dst == src0_addr) || (decode_in.dst == src1_addr));

	// Taken branch drops fetch and decode contents
	assign flush = branch_taken;

endmodule

`default_nettype wire

/* source/instr_memory.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module instr_memory (
	input  logic                  clk,
	input  cpu_pkg::imem_load_t   imem_load,
	input  logic [`CPU_WIDTH-1:0] addr,
	output cpu_pkg::instr_t       instr
);

	localparam int IADDR_BITS = $clog2(`CPU_IMEM_DEPTH);

	// Program store, one instruction per word
	logic [`CPU_WIDTH-1:0] mem [`CPU_IMEM_DEPTH];

	//////////////////////////////////////////////////////////////////////
	// Load port
	//////////////////////////////////////////////////////////////////////

	// Writes land on the next edge
	always_ff @(posedge clk) begin
		if (imem_load.we)
			mem[imem_load.addr[IADDR_BITS-1:0]] <= imem_load.data;
	end

	//////////////////////////////////////////////////////////////////////
	// Fetch port
	//////////////////////////////////////////////////////////////////////

	// Asynchronous read, upper pc bits dropped
	assign instr = cpu_pkg::instr_t'(mem[addr[IADDR_BITS-1:0]]);

endmodule

`default_nettype wire

/* tb/cpu_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_assertions (
	input logic             clk,
	input logic             reset,
	input logic             hlt,
	input cpu_pkg::retire_t retire
);

	//////////////////////////////////////////////////////////////////////
	// Halt and retirement rules
	//////////////////////////////////////////////////////////////////////

	// Sticky halt, only reset clears it
	hlt_held: assert property (@(posedge clk) (!reset && $past(hlt)) |-> hlt)
		else $error("hlt dropped while reset was low");

	// Pipeline drains to bubbles behind the HLT
	no_retire_after_halt: assert property (
		@(posedge clk) disable iff (reset) hlt |-> !retire.valid)
		else $error("retire pulse after hlt");

	// Writes to r0 never reach the retirement port
	retire_dst_nonzero: assert property (
		@(posedge clk) disable iff (reset) retire.valid |-> (retire.dst != '0))
		else $error("retire pulse with dst r0");

endmodule

bind cpu cpu_assertions pipeline_checks (
	.clk(clk),
	.reset(reset),
	.hlt(hlt),
	.retire(retire)
);

`default_nettype wire

/* tb/cpu_stim.txt */
# T name | P addr instr | W pc dst data, in retirement order | H halt_pc
# Fields hex; instr is opcode dst src0 src1, or opcode dst imm8
T alu_forwarding
P 00 A105
P 01 A203
P 02 0312
P 03 2431
P 04 4534
P 05 3651
P 06 F000
W 0000 1 0005
W 0001 2 0003
W 0002 3 0008
W 0003 4 0003
W 0004 5 FFF4
W 0005 6 0004
H 0006
T store_load_use
P 00 A120
P 01 A277
P 02 921F
P 03 831F
P 04 0432
P 05 F000
W 0000 1 0020
W 0001 2 0077
W 0003 3 0077
W 0004 4 00EE
H 0005
T branch_taken_untaken
P 00 A100
P 01 A201
P 02 C202
P 03 A311
P 04 A422
P 05 C102
P 06 A533
P 07 A644
P 08 0734
P 09 F000
W 0000 1 0000
W 0001 2 0001
W 0003 3 0011
W 0004 4 0022
W 0008 7 0033
H 0009
T llb_lhb_r0
P 00 A185
P 01 B13C
P 02 A055
P 03 0201
P 04 B2F0
P 05 F000
W 0000 1 FF85
W 0001 1 3C85
W 0003 2 3C85
W 0004 2 F085
H 0005
T halt_behind_branch
P 00 A100
P 01 C103
P 02 F000
P 03 A266
P 04 A377
P 05 A412
P 06 F000
P 07 A599
W 0000 1 0000
W 0005 4 0012
H 0006

/* tb/cpu_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module cpu_tb;

	localparam string STIM_FILE       = "tb/cpu_stim.txt";
	localparam int    RESET_CYCLES    = 10;
	localparam int    CYCLES_PER_WORD = 8;
	localparam int    CYCLES_PER_TEST = 100;

	logic                clk = 1'b0;
	logic                reset;
	cpu_pkg::imem_load_t imem_load;
	logic                hlt;
	cpu_pkg::word_t      halt_pc;
	cpu_pkg::retire_t    retire;

	// Parsed stimulus with per-test first indices and one end entry
	string          test_name [$];
	int             prog_first [$];
	int             trace_first [$];
	cpu_pkg::word_t halt_expect [$];
	cpu_pkg::word_t prog_addr [$];
	cpu_pkg::word_t prog_word [$];
	cpu_pkg::word_t trace_pc [$];
	cpu_pkg::word_t trace_dst [$];
	cpu_pkg::word_t trace_data [$];

	int   error_count     = 0;
	int   tests_failed    = 0;
	int   watchdog_cycles = 0;
	logic stim_ok;

	cpu DUT (
		.clk(clk),
		.reset(reset),
		.imem_load(imem_load),
		.hlt(hlt),
		.halt_pc(halt_pc),
		.retire(retire)
	);

	// 10 ns clock
	always #5 clk = ~clk;

	task automatic check_value(input string name, input cpu_pkg::word_t actual,
		input cpu_pkg::word_t expected);
		if (actual !== expected) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
			error_count++;
		end
	endtask

	// Drop trailing newline, carriage return and blanks
	function automatic string trim_line(input string s);
		string r;
		r = s;
		while (r.len() > 0 && r.getc(r.len() - 1) <= 8'h20)
			r = r.substr(0, r.len() - 2);
		return r;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus file
	//////////////////////////////////////////////////////////////////////

	task automatic read_stim();
		int             fd;
		int             fields;
		string          line;
		string          rest;
		byte            kind;
		cpu_pkg::word_t f1, f2, f3;
		stim_ok = 1'b1;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("Could not open stimulus file %s", STIM_FILE);
			stim_ok = 1'b0;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			line = trim_line(line);
			if (line.len() == 0 || line.getc(0) == "#")
				continue;
			kind = line.getc(0);
			rest = line.substr(1, line.len() - 1);
			// Records before the first T line belong to no test
			if (kind != "T" && test_name.size() == 0)
				stim_ok = 1'b0;
			case (kind)
				"T": begin
					test_name.push_back(line.substr(2, line.len() - 1));
					prog_first.push_back(prog_addr.size());
					trace_first.push_back(trace_pc.size());
				end
				"P": begin
					fields = $sscanf(rest, "%h %h", f1, f2);
					if (fields != 2)
						stim_ok = 1'b0;
					prog_addr.push_back(f1);
					prog_word.push_back(f2);
				end
				"W": begin
					fields = $sscanf(rest, "%h %h %h", f1, f2, f3);
					if (fields != 3)
						stim_ok = 1'b0;
					trace_pc.push_back(f1);
					trace_dst.push_back(f2);
					trace_data.push_back(f3);
				end
				"H": begin
					fields = $sscanf(rest, "%h", f1);
					if (fields != 1)
						stim_ok = 1'b0;
					halt_expect.push_back(f1);
				end
				default: stim_ok = 1'b0;
			endcase
		end
		$fclose(fd);
		// End entries close the last test
		prog_first.push_back(prog_addr.size());
		trace_first.push_back(trace_pc.size());
		if (test_name.size() == 0 || halt_expect.size() != test_name.size())
			stim_ok = 1'b0;
		if (!stim_ok)
			$display("Stimulus file %s is malformed", STIM_FILE);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Per-test sequence
	//////////////////////////////////////////////////////////////////////

	// Reset and program load start together with one word per cycle
	task automatic load_program(input int t);
		int i;
		int cycles;
		i      = prog_first[t];
		cycles = 0;
		while (cycles < RESET_CYCLES || i < prog_first[t + 1]) begin
			@(posedge clk);
			reset <= 1'b1;
			if (i < prog_first[t + 1]) begin
				imem_load <= '{we: 1'b1, addr: prog_addr[i], data: prog_word[i]};
				i++;
			end else begin
				imem_load <= '0;
			end
			cycles++;
		end
		// Last word lands on the edge that releases reset
		@(posedge clk);
		reset     <= 1'b0;
		imem_load <= '0;
	endtask

	task automatic run_test(input int t);
		int w_idx;
		int w_end;
		int errors_before;
		int retired;
		errors_before = error_count;
		load_program(t);
		w_idx   = trace_first[t];
		w_end   = trace_first[t + 1];
		retired = 0;
		// Sample on the falling edge once outputs have settled
		do begin
			@(negedge clk);
			if (retire.valid) begin
				retired++;
				if (w_idx < w_end) begin
					check_value("retire.pc", retire.pc, trace_pc[w_idx]);
					check_value("retire.dst", {{(`CPU_WIDTH-4){1'b0}}, retire.dst},
						trace_dst[w_idx]);
					check_value("retire.data", retire.data, trace_data[w_idx]);
					w_idx++;
				end else begin
					$display("Test %0d: unexpected retirement of r%0d at pc 0x%h",
						t + 1, retire.dst, retire.pc);
					error_count++;
				end
			end
		end while (!hlt);
		check_value("halt_pc", halt_pc, halt_expect[t]);
		if (w_idx < w_end) begin
			$display("Test %0d: halted with %0d expected retirements missing",
				t + 1, w_end - w_idx);
			error_count++;
		end
		if (error_count == errors_before) begin
			$display("Test %0d %s: passed, %0d retirements", t + 1, test_name[t], retired);
		end else begin
			$display("Test %0d %s: FAILED, %0d errors", t + 1, test_name[t],
				error_count - errors_before);
			tests_failed++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin : main_sequence
		int t;
		reset     <= 1'b1;
		imem_load <= '0;
		read_stim();
		if (stim_ok) begin
			// Budget grows with program length
			for (t = 0; t < test_name.size(); t++)
				watchdog_cycles += CYCLES_PER_WORD * (prog_first[t + 1] - prog_first[t])
					+ CYCLES_PER_TEST;
			for (t = 0; t < test_name.size(); t++)
				run_test(t);
		end else begin
			error_count++;
		end
		$display("%0d tests run, %0d failed, %0d errors",
			test_name.size(), tests_failed, error_count);
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial begin : watchdog
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("Timeout after %0d cycles, the DUT did not reach its halt", watchdog_cycles);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire
